// File: rs_pkg.sv
package rs_pkg;

    localparam int PREG_W = 6;   // physical register tag
    localparam int AREG_W = 5;   // architectural register
    localparam int ROB_W  = 6;   // reorder buffer index

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;

    // value 3 steers to no station
    typedef enum logic [1:0] {
        FU_ADD = 2'd0,
        FU_MUL = 2'd1,
        FU_DIV = 2'd2
    } fu_kind_e;

    // passed through the stations untouched
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_MUL,
        OP_MULH,
        OP_DIV,
        OP_REM
    } alu_op_e;

    typedef struct packed {
        logic     busy;    // slot holds a waiting instruction
        logic     ps1_v;
        logic     ps2_v;
        preg_t    ps1;
        preg_t    ps2;
        preg_t    pd;
        areg_t    rd;
        rob_idx_t rob;
        alu_op_e  op;
    } rs_entry_t;

    localparam int ADD_DEPTH_DEF = 8;
    localparam int MUL_DEPTH_DEF = 4;
    localparam int DIV_DEPTH_DEF = 4;

endpackage

// File: dispatch_if.sv
`timescale 1ns/1ps

// one renamed instruction heading for the stations
interface dispatch_if;
    import rs_pkg::*;

    logic     valid;
    fu_kind_e sel;       // target station
    preg_t    ps1;
    preg_t    ps2;
    logic     ps1_rdy;   // source already produced at rename
    logic     ps2_rdy;
    preg_t    pd;
    areg_t    rd;
    rob_idx_t rob;
    alu_op_e  op;

    modport sink (
        input valid,
        input sel,
        input ps1,
        input ps2,
        input ps1_rdy,
        input ps2_rdy,
        input pd,
        input rd,
        input rob,
        input op
    );

endinterface

// File: issue_if.sv
`timescale 1ns/1ps

// issue side of one station toward its functional unit
interface issue_if;
    import rs_pkg::*;

    logic     fu_busy;   // unit cannot take an instruction this cycle
    logic     issue;     // combinational strobe
    preg_t    pd;
    areg_t    rd;
    rob_idx_t rob;
    preg_t    ps1;
    preg_t    ps2;
    alu_op_e  op;

    // station side
    modport src (
        input  fu_busy,
        output issue,
        output pd,
        output rd,
        output rob,
        output ps1,
        output ps2,
        output op
    );

endinterface

// File: rs_issue_select.sv
`timescale 1ns/1ps

module rs_issue_select #(
    parameter int DEPTH = 4
) (
    input  rs_pkg::rs_entry_t        entries [DEPTH],
    input  logic                     fu_busy,
    output logic                     issue,
    output logic [$clog2(DEPTH)-1:0] slot,
    output rs_pkg::preg_t            pd,
    output rs_pkg::areg_t            rd,
    output rs_pkg::rob_idx_t         rob,
    output rs_pkg::preg_t            ps1,
    output rs_pkg::preg_t            ps2,
    output rs_pkg::alu_op_e          op
);
    import rs_pkg::*;

    localparam int SLOT_W = $clog2(DEPTH);

    logic              found;   // some entry has both sources ready
    logic [SLOT_W-1:0] pick;

    // lowest index wins
    always_comb
    begin
        found = 1'b0;
        pick  = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (!found && entries[i].busy && entries[i].ps1_v && entries[i].ps2_v)
            begin
                found = 1'b1;
                pick  = SLOT_W'(i);
            end
        end
    end

    always_comb
    begin
        // idle outputs held at zero
        issue = 1'b0;
        slot  = '0;
        pd    = '0;
        rd    = '0;
        rob   = '0;
        ps1   = '0;
        ps2   = '0;
        op    = OP_ADD;
        if (found && !fu_busy)
        begin
            issue = 1'b1;
            slot  = pick;
            pd    = entries[pick].pd;
            rd    = entries[pick].rd;
            rob   = entries[pick].rob;
            ps1   = entries[pick].ps1;
            ps2   = entries[pick].ps2;
            op    = entries[pick].op;
        end
    end

endmodule

// File: rs_bank.sv
`timescale 1ns/1ps

module rs_bank #(
    parameter int               DEPTH = 4,
    parameter rs_pkg::fu_kind_e KIND  = rs_pkg::FU_ADD
) (
    input  logic          clk,
    input  logic          rst,
    dispatch_if.sink      disp,
    input  logic          wake_valid,   // registered cdb strobe
    input  rs_pkg::preg_t wake_tag,
    output logic          full,
    issue_if.src          iss
);
    import rs_pkg::*;

    localparam int SLOT_W = $clog2(DEPTH);

    rs_entry_t         entries [DEPTH];
    rs_entry_t         new_entry;
    logic [SLOT_W-1:0] free_slot;   // lowest unused slot
    logic [SLOT_W-1:0] iss_slot;    // slot leaving this cycle
    logic              has_free;
    logic              accept;
    logic              wake_ps1;
    logic              wake_ps2;

    // free slot search
    always_comb
    begin
        has_free  = 1'b0;
        free_slot = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (!has_free && !entries[i].busy)
            begin
                has_free  = 1'b1;
                free_slot = SLOT_W'(i);
            end
        end
    end

    assign full   = !has_free;   // level that ignores dispatch
    assign accept = disp.valid && (disp.sel == KIND) && has_free;

    // a wakeup landing on the insert edge must not be missed
    assign wake_ps1 = wake_valid && (wake_tag == disp.ps1);
    assign wake_ps2 = wake_valid && (wake_tag == disp.ps2);

    always_comb
    begin
        new_entry       = '0;
        new_entry.busy  = 1'b1;
        new_entry.ps1_v = disp.ps1_rdy || wake_ps1;
        new_entry.ps2_v = disp.ps2_rdy || wake_ps2;
        new_entry.ps1   = disp.ps1;
        new_entry.ps2   = disp.ps2;
        new_entry.pd    = disp.pd;
        new_entry.rd    = disp.rd;
        new_entry.rob   = disp.rob;
        new_entry.op    = disp.op;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            // all slots free
            for (int i = 0; i < DEPTH; i++)
            begin
                entries[i].busy <= 1'b0;
            end
        end
        else
        begin
            if (wake_valid)
            begin
                for (int i = 0; i < DEPTH; i++)
                begin
                    if (entries[i].ps1 == wake_tag)
                    begin
                        entries[i].ps1_v <= 1'b1;
                    end
                    if (entries[i].ps2 == wake_tag)
                    begin
                        entries[i].ps2_v <= 1'b1;
                    end
                end
            end

            if (iss.issue)
            begin
                entries[iss_slot].busy <= 1'b0;   // release on the issue edge
            end

            // free slot never equals the issuing one
            if (accept)
            begin
                entries[free_slot] <= new_entry;
            end
        end
    end

    rs_issue_select #(
        .DEPTH (DEPTH)
    ) i_rs_issue_select (
        .entries (entries),
        .fu_busy (iss.fu_busy),
        .issue   (iss.issue),
        .slot    (iss_slot),
        .pd      (iss.pd),
        .rd      (iss.rd),
        .rob     (iss.rob),
        .ps1     (iss.ps1),
        .ps2     (iss.ps2),
        .op      (iss.op)
    );

endmodule

// File: reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int ADD_DEPTH = rs_pkg::ADD_DEPTH_DEF,
    parameter int MUL_DEPTH = rs_pkg::MUL_DEPTH_DEF,
    parameter int DIV_DEPTH = rs_pkg::DIV_DEPTH_DEF
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             dispatch_valid,
    input  rs_pkg::fu_kind_e dispatch_sel,
    input  rs_pkg::preg_t    ps1,
    input  rs_pkg::preg_t    ps2,
    input  logic             ps1_rdy,
    input  logic             ps2_rdy,
    input  rs_pkg::preg_t    pd,
    input  rs_pkg::areg_t    rd,
    input  rs_pkg::rob_idx_t rob,
    input  rs_pkg::alu_op_e  op,

    input  logic             cdb_valid,
    input  rs_pkg::preg_t    cdb_tag,

    input  logic             add_fu_busy,
    input  logic             mul_fu_busy,
    input  logic             div_fu_busy,

    output logic             add_full,
    output logic             mul_full,
    output logic             div_full,

    output logic             add_issue,
    output rs_pkg::preg_t    add_pd,
    output rs_pkg::areg_t    add_rd,
    output rs_pkg::rob_idx_t add_rob,
    output rs_pkg::preg_t    add_ps1,
    output rs_pkg::preg_t    add_ps2,
    output rs_pkg::alu_op_e  add_op,

    output logic             mul_issue,
    output rs_pkg::preg_t    mul_pd,
    output rs_pkg::areg_t    mul_rd,
    output rs_pkg::rob_idx_t mul_rob,
    output rs_pkg::preg_t    mul_ps1,
    output rs_pkg::preg_t    mul_ps2,
    output rs_pkg::alu_op_e  mul_op,

    output logic             div_issue,
    output rs_pkg::preg_t    div_pd,
    output rs_pkg::areg_t    div_rd,
    output rs_pkg::rob_idx_t div_rob,
    output rs_pkg::preg_t    div_ps1,
    output rs_pkg::preg_t    div_ps2,
    output rs_pkg::alu_op_e  div_op
);
    import rs_pkg::*;

    logic  wake_valid;   // cdb delayed one cycle for all banks
    preg_t wake_tag;

    dispatch_if disp ();
    issue_if    add_iss ();
    issue_if    mul_iss ();
    issue_if    div_iss ();

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wake_valid <= 1'b0;
        end
        else
        begin
            wake_valid <= cdb_valid;
        end
        wake_tag <= cdb_tag;
    end

    // every bank sees the same dispatch
    assign disp.valid   = dispatch_valid;
    assign disp.sel     = dispatch_sel;
    assign disp.ps1     = ps1;
    assign disp.ps2     = ps2;
    assign disp.ps1_rdy = ps1_rdy;
    assign disp.ps2_rdy = ps2_rdy;
    assign disp.pd      = pd;
    assign disp.rd      = rd;
    assign disp.rob     = rob;
    assign disp.op      = op;

    assign add_iss.fu_busy = add_fu_busy;
    assign mul_iss.fu_busy = mul_fu_busy;
    assign div_iss.fu_busy = div_fu_busy;

    assign add_issue = add_iss.issue;
    assign add_pd    = add_iss.pd;
    assign add_rd    = add_iss.rd;
    assign add_rob   = add_iss.rob;
    assign add_ps1   = add_iss.ps1;
    assign add_ps2   = add_iss.ps2;
    assign add_op    = add_iss.op;

    assign mul_issue = mul_iss.issue;
    assign mul_pd    = mul_iss.pd;
    assign mul_rd    = mul_iss.rd;
    assign mul_rob   = mul_iss.rob;
    assign mul_ps1   = mul_iss.ps1;
    assign mul_ps2   = mul_iss.ps2;
    assign mul_op    = mul_iss.op;

    assign div_issue = div_iss.issue;
    assign div_pd    = div_iss.pd;
    assign div_rd    = div_iss.rd;
    assign div_rob   = div_iss.rob;
    assign div_ps1   = div_iss.ps1;
    assign div_ps2   = div_iss.ps2;
    assign div_op    = div_iss.op;

    rs_bank #(
        .DEPTH (ADD_DEPTH),
        .KIND  (FU_ADD)
    ) i_add_bank (
        .clk        (clk),
        .rst        (rst),
        .disp       (disp),
        .wake_valid (wake_valid),
        .wake_tag   (wake_tag),
        .full       (add_full),
        .iss        (add_iss)
    );

    rs_bank #(
        .DEPTH (MUL_DEPTH),
        .KIND  (FU_MUL)
    ) i_mul_bank (
        .clk        (clk),
        .rst        (rst),
        .disp       (disp),
        .wake_valid (wake_valid),
        .wake_tag   (wake_tag),
        .full       (mul_full),
        .iss        (mul_iss)
    );

    rs_bank #(
        .DEPTH (DIV_DEPTH),
        .KIND  (FU_DIV)
    ) i_div_bank (
        .clk        (clk),
        .rst        (rst),
        .disp       (disp),
        .wake_valid (wake_valid),
        .wake_tag   (wake_tag),
        .full       (div_full),
        .iss        (div_iss)
    );

endmodule

// File: tb_reservation_station.sv
`timescale 1ns/1ps

module tb_reservation_station;
    import rs_pkg::*;

    localparam int NCOL      = 30;   // 15 input and 15 expected columns
    localparam int MAX_ROWS  = 64;
    localparam int SLACK     = 20;   // spare cycles on top of the stimulus length
    localparam int ROB_SLOTS = 1 << ROB_W;

    logic     clk;
    logic     rst;
    logic     dispatch_valid;
    fu_kind_e dispatch_sel;
    preg_t    ps1, ps2, pd;
    logic     ps1_rdy, ps2_rdy;
    areg_t    rd;
    rob_idx_t rob;
    alu_op_e  op;
    logic     cdb_valid;
    preg_t    cdb_tag;
    logic     add_fu_busy, mul_fu_busy, div_fu_busy;
    logic     add_full, mul_full, div_full;
    logic     add_issue, mul_issue, div_issue;
    preg_t    add_pd, mul_pd, div_pd;
    areg_t    add_rd, mul_rd, div_rd;
    rob_idx_t add_rob, mul_rob, div_rob;
    preg_t    add_ps1, mul_ps1, div_ps1;
    preg_t    add_ps2, mul_ps2, div_ps2;
    alu_op_e  add_op, mul_op, div_op;

    logic [7:0] stim [NCOL*MAX_ROWS];   // one hex word per column
    int         n_rows;
    int         cur_row = 0;
    int         cycles = 0;
    int         cycle_limit = MAX_ROWS + SLACK;

    areg_t      sent_rd  [ROB_SLOTS];   // dispatched fields by rob
    preg_t      sent_ps1 [ROB_SLOTS];
    preg_t      sent_ps2 [ROB_SLOTS];

    reservation_station i_reservation_station (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] stim_word(input int r, input int c);
        return stim[r * NCOL + c];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s row %0d: expected %h got %h", name, cur_row, exp, got));
    endtask

    task automatic check_preg(input string name, input preg_t exp, input preg_t got);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s row %0d: expected %h got %h", name, cur_row, exp, got));
    endtask

    task automatic check_areg(input string name, input areg_t exp, input areg_t got);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s row %0d: expected %h got %h", name, cur_row, exp, got));
    endtask

    task automatic check_rob(input string name, input rob_idx_t exp, input rob_idx_t got);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s row %0d: expected %h got %h", name, cur_row, exp, got));
    endtask

    task automatic check_op(input string name, input alu_op_e exp, input alu_op_e got);
        if (got !== exp)
            fail_run($sformatf("Mismatch %s row %0d: expected %h got %h", name, cur_row, exp, got));
    endtask

    // issue, pd, rob, op of one unit start at column base
    task automatic check_unit(input string fu, input int r, input int base,
                              input logic issue, input preg_t got_pd,
                              input rob_idx_t got_rob, input alu_op_e got_op,
                              input areg_t got_rd, input preg_t got_ps1,
                              input preg_t got_ps2);
        logic     exp_issue;
        rob_idx_t exp_rob;
        exp_issue = 1'(stim_word(r, base));
        exp_rob   = rob_idx_t'(stim_word(r, base + 2));
        check_flag({fu, "_issue"}, exp_issue, issue);
        check_preg({fu, "_pd"}, preg_t'(stim_word(r, base + 1)), got_pd);
        check_rob({fu, "_rob"}, exp_rob, got_rob);
        check_op({fu, "_op"}, alu_op_e'(4'(stim_word(r, base + 3))), got_op);
        // rd and sources as dispatched and zero while idle
        check_areg({fu, "_rd"}, exp_issue ? sent_rd[exp_rob] : areg_t'(0), got_rd);
        check_preg({fu, "_ps1"}, exp_issue ? sent_ps1[exp_rob] : preg_t'(0), got_ps1);
        check_preg({fu, "_ps2"}, exp_issue ? sent_ps2[exp_rob] : preg_t'(0), got_ps2);
    endtask

    task automatic drive_row(input int r);
        dispatch_valid <= 1'(stim_word(r, 0));
        dispatch_sel   <= fu_kind_e'(2'(stim_word(r, 1)));
        ps1            <= preg_t'(stim_word(r, 2));
        ps2            <= preg_t'(stim_word(r, 3));
        ps1_rdy        <= 1'(stim_word(r, 4));
        ps2_rdy        <= 1'(stim_word(r, 5));
        pd             <= preg_t'(stim_word(r, 6));
        rd             <= areg_t'(stim_word(r, 7));
        rob            <= rob_idx_t'(stim_word(r, 8));
        op             <= alu_op_e'(4'(stim_word(r, 9)));
        cdb_valid      <= 1'(stim_word(r, 10));
        cdb_tag        <= preg_t'(stim_word(r, 11));
        add_fu_busy    <= 1'(stim_word(r, 12));
        mul_fu_busy    <= 1'(stim_word(r, 13));
        div_fu_busy    <= 1'(stim_word(r, 14));
    endtask

    // an issue hands these fields back unchanged
    task automatic record_dispatch(input int r);
        rob_idx_t idx;
        idx = rob_idx_t'(stim_word(r, 8));
        if (1'(stim_word(r, 0)))
        begin
            sent_rd[idx]  = areg_t'(stim_word(r, 7));
            sent_ps1[idx] = preg_t'(stim_word(r, 2));
            sent_ps2[idx] = preg_t'(stim_word(r, 3));
        end
    endtask

    task automatic load_stimulus();
        int fd;
        fd = $fopen("rs_stimulus.txt", "r");
        if (fd == 0)
        begin
            fail_run("cannot open rs_stimulus.txt");
        end
        else
        begin
            $fclose(fd);
            $readmemh("rs_stimulus.txt", stim);
            n_rows = 0;
            while (n_rows < MAX_ROWS && stim_word(n_rows, 0) !== 8'hff)   // ff ends the data
                n_rows++;
            if (n_rows == MAX_ROWS)
                fail_run("stimulus file has no end marker");
            cycle_limit = n_rows + SLACK;
        end
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit)
            fail_run($sformatf("run did not finish within %0d cycles", cycle_limit));
    end

    initial
    begin
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_sel   = FU_ADD;
        ps1            = '0;
        ps2            = '0;
        ps1_rdy        = 1'b0;
        ps2_rdy        = 1'b0;
        pd             = '0;
        rd             = '0;
        rob            = '0;
        op             = OP_ADD;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        add_fu_busy    = 1'b0;
        mul_fu_busy    = 1'b0;
        div_fu_busy    = 1'b0;
        load_stimulus();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < n_rows; r++)
        begin
            @(posedge clk);
            cur_row = r;
            drive_row(r);
            record_dispatch(r);
            @(negedge clk);   // outputs settled for this row
            check_flag("add_full", 1'(stim_word(r, 15)), add_full);
            check_flag("mul_full", 1'(stim_word(r, 16)), mul_full);
            check_flag("div_full", 1'(stim_word(r, 17)), div_full);
            check_unit("add", r, 18, add_issue, add_pd, add_rob, add_op,
                       add_rd, add_ps1, add_ps2);
            check_unit("mul", r, 22, mul_issue, mul_pd, mul_rob, mul_op,
                       mul_rd, mul_ps1, mul_ps2);
            check_unit("div", r, 26, div_issue, div_pd, div_rob, div_op,
                       div_rd, div_ps1, div_ps2);
        end
        if (n_rows == 0)
        begin
            fail_run("stimulus file holds no rows");
        end
        else
        begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: rs_stimulus.txt
// in:  dv sel ps1 ps2 r1 r2 pd rd rob op  cdb_v cdb_tag  add_busy mul_busy div_busy
// exp: add/mul/div full, then issue pd rob op for add, mul and div; ff ends the data
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 0 01 02 1 1 10 03 01 1  0 00  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 1 03 04 1 1 11 04 02 6  0 00  0 0 0  0 0 0  1 10 01 1  0 00 00 0  0 00 00 0
1 2 05 06 1 1 12 05 03 8  0 00  0 0 0  0 0 0  0 00 00 0  1 11 02 6  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  0 00 00 0  0 00 00 0  1 12 03 8
1 0 20 21 0 1 13 06 04 2  0 00  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  1 22  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 20  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  1 20  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  1 13 04 2  0 00 00 0  0 00 00 0
1 1 07 08 1 1 14 07 05 6  0 00  0 1 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 1 09 0a 1 1 15 08 06 7  0 00  0 1 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 1 0b 0c 1 1 16 09 07 6  0 00  0 1 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 1 0d 0e 1 1 17 0a 08 7  0 00  0 1 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 1 0f 10 1 1 18 0b 09 6  0 00  0 1 0  0 1 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 1 0  0 1 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 1 0  0 00 00 0  1 14 05 6  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  0 00 00 0  1 15 06 7  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  0 00 00 0  1 16 07 6  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  0 00 00 0  1 17 08 7  0 00 00 0
1 0 01 02 1 1 19 0c 0a 3  0 00  1 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 0 03 04 1 1 1a 0d 0b 4  0 00  1 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  1 19 0a 3  0 00 00 0  0 00 00 0
1 0 05 06 1 1 1b 0e 0c 5  0 00  1 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  1 1b 0c 5  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  1 1a 0b 4  0 00 00 0  0 00 00 0
1 0 01 02 1 1 1c 0f 0d 1  0 00  1 1 1  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 1 03 04 1 1 1d 10 0e 7  0 00  1 1 1  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 2 05 06 1 1 1e 11 0f 9  0 00  1 1 1  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  1 1c 0d 1  1 1d 0e 7  1 1e 0f 9
1 0 07 08 1 1 1f 12 10 2  0 00  0 0 1  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 2 09 0a 1 1 20 13 11 8  0 00  0 0 1  0 0 0  1 1f 10 2  0 00 00 0  0 00 00 0
1 1 0b 0c 1 1 21 14 12 6  0 00  0 0 1  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 1  0 0 0  0 00 00 0  1 21 12 6  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  0 00 00 0  0 00 00 0  1 20 11 8
0 0 00 00 0 0 00 00 00 0  1 30  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
1 0 30 31 0 1 22 15 13 3  0 00  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  1 22 13 3  0 00 00 0  0 00 00 0
1 3 01 02 1 1 23 16 14 0  0 00  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
0 0 00 00 0 0 00 00 00 0  0 00  0 0 0  0 0 0  0 00 00 0  0 00 00 0  0 00 00 0
ff

// File: compile.f
rs_pkg.sv
dispatch_if.sv
issue_if.sv
rs_issue_select.sv
rs_bank.sv
reservation_station.sv
tb_reservation_station.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Mdir obj_dir -o sim_tb \
    --top-module tb_reservation_station -f compile.f

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1
